// ==== memPkg.sv ====
package memPkg;

    // bus widths
    localparam int addrWidth = 17;
    localparam int dataWidth = 32;

    // access length field, in bytes
    localparam int lenBits = 3;
    localparam logic [lenBits-1:0] lenByte = 3'd1;
    localparam logic [lenBits-1:0] lenHalf = 3'd2;
    localparam logic [lenBits-1:0] lenWord = 3'd4;

    // which requester holds the RAM
    localparam int ownerWidth = 2;
    localparam logic [ownerWidth-1:0] ownerIdle  = 2'b00;
    localparam logic [ownerWidth-1:0] ownerData  = 2'b01;
    localparam logic [ownerWidth-1:0] ownerFetch = 2'b10;

    // byte RAM holds 2**ramDepthLog bytes
    localparam int ramDepthLog = 12;

    // controller FSM states
    localparam int stateWidth = 2;
    localparam logic [stateWidth-1:0] stateIdle      = 2'd0;
    localparam logic [stateWidth-1:0] stateReadInst  = 2'd1;
    localparam logic [stateWidth-1:0] stateReadData  = 2'd2;
    localparam logic [stateWidth-1:0] stateWriteData = 2'd3;

    // one memory word, either as byte lanes or as a whole
    // lane 0 sits at the lowest address
    typedef union packed {
        logic [3:0][7:0]         bytes;
        logic [dataWidth-1:0]    word;
    } memWord;

endpackage

// ==== byteRam.sv ====
`timescale 1ns/10ps

module byteRam (
    input  logic                          clk,
    input  logic [memPkg::addrWidth-1:0]  addr,
    input  logic                          we,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata
);

    // no initial contents
    logic [7:0] mem [0:(1 << memPkg::ramDepthLog)-1];

    logic [memPkg::ramDepthLog-1:0] index;

    // upper address bits fold onto the same bytes
    assign index = addr[memPkg::ramDepthLog-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

// ==== memCtrl.sv ====
`timescale 1ns/10ps

module memCtrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,

    // instruction fetch requester
    input  logic                              fetchEn,
    input  logic [memPkg::addrWidth-1:0]      fetchAddr,

    // load/store requester
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memPkg::lenBits-1:0]        dataLen,
    input  logic [memPkg::addrWidth-1:0]      dataAddr,
    input  logic [memPkg::dataWidth-1:0]      dataWdata,

    output logic                              fetchDone,
    output logic [memPkg::dataWidth-1:0]      fetchInst,
    output logic                              dataDone,
    output logic [memPkg::dataWidth-1:0]      dataRdata,
    output logic [memPkg::ownerWidth-1:0]     owner,

    // byte RAM side
    output logic [memPkg::addrWidth-1:0]      ramAddr,
    output logic                              ramWe,
    output logic [7:0]                        ramWdata,
    input  logic [7:0]                        ramRdata
);

    logic                             active;
    logic [memPkg::stateWidth-1:0]    state;
    logic [memPkg::lenBits-1:0]       stage;
    logic                             doneQ;
    logic [memPkg::addrWidth-1:0]     addrQ;
    logic [memPkg::addrWidth-1:0]     issueAddr;
    logic [memPkg::addrWidth-1:0]     ramAddrQ;
    logic [memPkg::lenBits-1:0]       lenQ;
    memPkg::memWord                   wdataQ;
    memPkg::memWord                   rdWord;
    logic [1:0]                       lane;
    logic                             lastRead;
    logic                             lastStore;
    logic                             reading;

    assign active = rdy & ~ioBufferFull;

    // byte offset from the latched start address
    assign issueAddr = addrQ + {{(memPkg::addrWidth - memPkg::lenBits){1'b0}}, stage};

    // returned byte belongs to the address issued one stage earlier
    assign lane = stage[1:0] - 2'd1;

    assign lastRead  = (stage == lenQ);
    assign lastStore = (stage == lenQ - 1'b1);
    assign reading   = (state == memPkg::stateReadInst) || (state == memPkg::stateReadData);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::stateIdle;
            stage <= '0;
            doneQ <= 1'b0;
        end else if (active) begin
            case (state)
                memPkg::stateIdle: begin
                    stage <= '0;
                    // data side wins a tie
                    if (dataEn) begin
                        state <= dataStore ? memPkg::stateWriteData : memPkg::stateReadData;
                    end else if (fetchEn) begin
                        state <= memPkg::stateReadInst;
                    end
                end
                memPkg::stateWriteData: begin
                    if (doneQ) begin
                        state <= memPkg::stateIdle;
                        doneQ <= 1'b0;
                    end else if (lastStore) begin
                        doneQ <= 1'b1;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                default: begin
                    // both read states walk the same way
                    if (doneQ) begin
                        state <= memPkg::stateIdle;
                        doneQ <= 1'b0;
                    end else if (lastRead) begin
                        doneQ <= 1'b1;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
            endcase
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk) begin
        if (active) begin
            ramAddrQ <= issueAddr;
            if (state == memPkg::stateIdle) begin
                // cleared here so short loads come out zero-extended
                rdWord.word <= '0;
                if (dataEn) begin
                    addrQ       <= dataAddr;
                    lenQ        <= dataLen;
                    wdataQ.word <= dataWdata;
                end else begin
                    addrQ <= fetchAddr;
                    lenQ  <= memPkg::lenWord;
                end
            end else if (reading && !doneQ && stage != '0) begin
                rdWord.bytes[lane] <= ramRdata;
            end
        end
    end

    // the RAM reads every clock, so a stall must keep re-reading the
    // address of the last active cycle or the pending byte is lost
    assign ramAddr  = active ? issueAddr : ramAddrQ;
    assign ramWe    = active && (state == memPkg::stateWriteData) && !doneQ;
    assign ramWdata = wdataQ.bytes[stage[1:0]];

    assign fetchDone = active && doneQ && (state == memPkg::stateReadInst);
    assign dataDone  = active && doneQ &&
                       ((state == memPkg::stateReadData) || (state == memPkg::stateWriteData));

    assign fetchInst = rdWord.word;
    assign dataRdata = rdWord.word;

    always_comb begin
        case (state)
            memPkg::stateReadInst:  owner = memPkg::ownerFetch;
            memPkg::stateReadData:  owner = memPkg::ownerData;
            memPkg::stateWriteData: owner = memPkg::ownerData;
            default:                owner = memPkg::ownerIdle;
        endcase
    end

endmodule

// ==== memSystem.sv ====
`timescale 1ns/10ps

module memSystem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,

    input  logic                              fetchEn,
    input  logic [memPkg::addrWidth-1:0]      fetchAddr,

    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memPkg::lenBits-1:0]        dataLen,
    input  logic [memPkg::addrWidth-1:0]      dataAddr,
    input  logic [memPkg::dataWidth-1:0]      dataWdata,

    output logic                              fetchDone,
    output logic [memPkg::dataWidth-1:0]      fetchInst,
    output logic                              dataDone,
    output logic [memPkg::dataWidth-1:0]      dataRdata,
    output logic [memPkg::ownerWidth-1:0]     owner
);

    // controller to RAM
    logic [memPkg::addrWidth-1:0] ramAddr;
    logic                         ramWe;
    logic [7:0]                   ramWdata;
    logic [7:0]                   ramRdata;

    memCtrl i_memCtrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata),
        .ramRdata     (ramRdata)
    );

    byteRam i_byteRam (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first 3 rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/10ps

module tbChecker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,
    input  logic                              fetchEn,
    input  logic [memPkg::addrWidth-1:0]      fetchAddr,
    input  logic [memPkg::dataWidth-1:0]      fetchExp,
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memPkg::lenBits-1:0]        dataLen,
    input  logic [memPkg::addrWidth-1:0]      dataAddr,
    input  logic [memPkg::dataWidth-1:0]      dataWdata,
    input  logic [memPkg::dataWidth-1:0]      dataExp,
    input  logic                              fetchDone,
    input  logic [memPkg::dataWidth-1:0]      fetchInst,
    input  logic                              dataDone,
    input  logic [memPkg::dataWidth-1:0]      dataRdata,
    input  logic [memPkg::ownerWidth-1:0]     owner,
    input  logic                              runDone,
    output int                                errorCount
);

    // expected RAM contents, built from the stores seen so far
    logic [7:0] shadow [0:(1 << memPkg::ramDepthLog)-1];

    logic                             busy = 1'b0;
    logic                             reqFetch;
    logic                             reqStore;
    logic [memPkg::addrWidth-1:0]     reqAddr;
    logic [memPkg::lenBits-1:0]       reqLen;
    logic [memPkg::dataWidth-1:0]     reqWdata;
    logic [memPkg::dataWidth-1:0]     reqExp;
    int                               activeCount = 0;
    int                               target = 0;
    int                               checks = 0;
    int                               errors = 0;
    int                               fetches = 0;
    int                               loads = 0;
    int                               stores = 0;
    logic                             reported = 1'b0;

    assign errorCount = errors;

    // little-endian, zero-extended
    function automatic logic [31:0] shadowRead(input logic [memPkg::addrWidth-1:0] addr,
                                               input logic [memPkg::lenBits-1:0] len);
        logic [31:0] word;
        logic [memPkg::ramDepthLog-1:0] index;
        word = '0;
        index = addr[memPkg::ramDepthLog-1:0];
        for (int k = 0; k < int'(len); k++) begin
            word[8*k +: 8] = shadow[index];
            index = index + 1'b1;
        end
        return word;
    endfunction

    task automatic shadowWrite();
        logic [memPkg::ramDepthLog-1:0] index;
        index = reqAddr[memPkg::ramDepthLog-1:0];
        for (int k = 0; k < int'(reqLen); k++) begin
            shadow[index] = reqWdata[8*k +: 8];
            index = index + 1'b1;
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin : monitor
        logic active;
        logic doneNow;
        logic [memPkg::ownerWidth-1:0] expOwner;
        logic [memPkg::dataWidth-1:0]  result;
        active = rdy && !ioBufferFull;
        if (rst) begin
            busy = 1'b0;
        end else begin
            // latency counted in active cycles from acceptance
            if (busy && active) begin
                activeCount++;
            end
            doneNow = busy && active && (activeCount == target);
            if (!busy) begin
                expOwner = memPkg::ownerIdle;
            end else if (reqFetch) begin
                expOwner = memPkg::ownerFetch;
            end else begin
                expOwner = memPkg::ownerData;
            end
            compareValue("owner", 32'(owner), 32'(expOwner));
            compareValue("fetchDone", 32'(fetchDone), 32'(doneNow && reqFetch));
            compareValue("dataDone", 32'(dataDone), 32'(doneNow && !reqFetch));
            if (busy && (reqFetch ? !fetchEn : !dataEn)) begin
                errors++;
                $display("request enable dropped before its done pulse at %0t ns", $time);
            end
            if (doneNow) begin
                result = reqFetch ? fetchInst : dataRdata;
                if (reqStore) begin
                    shadowWrite();
                end else begin
                    compareValue(reqFetch ? "fetchInst" : "dataRdata", result, reqExp);
                    compareValue(reqFetch ? "fetchInst(shadow)" : "dataRdata(shadow)",
                                 result, shadowRead(reqAddr, reqLen));
                end
                busy = 1'b0;
            end else if (!busy && active && (dataEn || fetchEn)) begin
                // data request wins a tie
                busy        = 1'b1;
                activeCount = 0;
                reqFetch    = !dataEn;
                reqStore    = dataEn && dataStore;
                reqAddr     = dataEn ? dataAddr : fetchAddr;
                reqLen      = dataEn ? dataLen : memPkg::lenWord;
                reqWdata    = dataWdata;
                reqExp      = dataEn ? dataExp : fetchExp;
                target      = int'(reqLen) + (reqStore ? 1 : 2);
                if (reqFetch) begin
                    fetches++;
                end else if (reqStore) begin
                    stores++;
                end else begin
                    loads++;
                end
            end
        end
        if (runDone && !reported) begin
            reported = 1'b1;
            $display("checker: %0d checks, %0d errors, %0d fetches, %0d loads, %0d stores",
                     checks, errors, fetches, loads, stores);
        end
    end

endmodule

// ==== memSystem_assert.sv ====
`timescale 1ns/10ps

module handshakeChecks (
    input logic                          clk,
    input logic                          rst,
    input logic                          rdy,
    input logic                          ioBufferFull,
    input logic                          fetchDone,
    input logic                          dataDone,
    input logic                          ramWe,
    input logic [memPkg::addrWidth-1:0]  ramAddr,
    input logic [memPkg::ownerWidth-1:0] owner
);

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone stayed high for more than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone stayed high for more than one cycle");

    // frozen RAM side: no write, read address held
    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        (!rdy || ioBufferFull) |-> (!ramWe && $stable(ramAddr)))
        else $error("RAM write or address change while the controller is stalled");

    // data side held the RAM up to its done
    dataDoneOwner: assert property (@(posedge clk) disable iff (rst)
        dataDone |-> ((owner != memPkg::ownerFetch) &&
                      ($past(owner) == memPkg::ownerData)))
        else $error("dataDone while the load/store path does not own the RAM");

endmodule

bind memCtrl handshakeChecks handshakeChecksInst (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .ioBufferFull (ioBufferFull),
    .fetchDone    (fetchDone),
    .dataDone     (dataDone),
    .ramWe        (ramWe),
    .ramAddr      (ramAddr),
    .owner        (owner)
);

// ==== tbMemSystem.sv ====
`timescale 1ns/10ps

module tbMemSystem;

    logic                             clk;
    logic                             rst;
    logic                             rdy;
    logic                             ioBufferFull;
    logic                             fetchEn;
    logic [memPkg::addrWidth-1:0]     fetchAddr;
    logic [memPkg::dataWidth-1:0]     fetchExp;
    logic                             dataEn;
    logic                             dataStore;
    logic [memPkg::lenBits-1:0]       dataLen;
    logic [memPkg::addrWidth-1:0]     dataAddr;
    logic [memPkg::dataWidth-1:0]     dataWdata;
    logic [memPkg::dataWidth-1:0]     dataExp;
    logic                             fetchDone;
    logic [memPkg::dataWidth-1:0]     fetchInst;
    logic                             dataDone;
    logic [memPkg::dataWidth-1:0]     dataRdata;
    logic [memPkg::ownerWidth-1:0]    owner;
    logic                             runDone;
    logic                             stallOn;
    int                               errorCount;

    // trace contents
    logic [7:0]                       opList[$];
    logic [memPkg::addrWidth-1:0]     addrList[$];
    logic [memPkg::lenBits-1:0]       lenList[$];
    logic [memPkg::dataWidth-1:0]     valueList[$];
    logic                             pairList[$];

    // separate streams for gaps and stalls
    logic [15:0]                      gapLfsr = 16'd22;
    logic [15:0]                      stallLfsr = 16'd22;
    logic                             traceLoaded = 1'b0;
    int                               limitCycles = 0;

    tbClock clockGen (
        .clk (clk),
        .rst (rst)
    );

    memSystem i_memSystem (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner)
    );

    tbChecker checkerInst (
        .clk (clk), .rst (rst), .rdy (rdy), .ioBufferFull (ioBufferFull),
        .fetchEn (fetchEn), .fetchAddr (fetchAddr), .fetchExp (fetchExp),
        .dataEn (dataEn), .dataStore (dataStore), .dataLen (dataLen),
        .dataAddr (dataAddr), .dataWdata (dataWdata), .dataExp (dataExp),
        .fetchDone (fetchDone), .fetchInst (fetchInst),
        .dataDone (dataDone), .dataRdata (dataRdata), .owner (owner),
        .runDone (runDone), .errorCount (errorCount)
    );

    // galois LFSR step
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // one step per bit taken
    task automatic drawBits(input int count, inout logic [15:0] state, output int value);
        value = 0;
        for (int k = 0; k < count; k++) begin
            value = (value << 1) | int'(state[0]);
            state = lfsrStep(state);
        end
    endtask

    task automatic loadTrace(output logic ok);
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [memPkg::addrWidth-1:0] addr;
        logic [memPkg::lenBits-1:0] len;
        logic [memPkg::dataWidth-1:0] value;
        int pair;
        fd = $fopen("mem_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %d %h %d", op, addr, len, value, pair);
                    if (n == 5) begin
                        opList.push_back(op);
                        addrList.push_back(addr);
                        lenList.push_back(len);
                        valueList.push_back(value);
                        pairList.push_back(pair != 0);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (opList.size() > 0);
    endtask

    task automatic driveData(input int idx);
        dataEn    <= 1'b1;
        dataStore <= (opList[idx] == "S");
        dataLen   <= lenList[idx];
        dataAddr  <= addrList[idx];
        dataWdata <= (opList[idx] == "S") ? valueList[idx] : '0;
        dataExp   <= valueList[idx];
    endtask

    task automatic driveFetch(input int idx);
        fetchEn   <= 1'b1;
        fetchAddr <= addrList[idx];
        fetchExp  <= valueList[idx];
    endtask

    // hold each enable until its own done pulse
    task automatic waitDone(input logic needData, input logic needFetch);
        logic waitData;
        logic waitFetch;
        waitData = needData;
        waitFetch = needFetch;
        while (waitData || waitFetch) begin
            @(posedge clk);
            if (waitData && dataDone) begin
                dataEn <= 1'b0;
                waitData = 1'b0;
            end
            if (waitFetch && fetchDone) begin
                fetchEn <= 1'b0;
                waitFetch = 1'b0;
            end
        end
    endtask

    task automatic runPass();
        int i;
        int gap;
        logic paired;
        i = 0;
        while (i < opList.size()) begin
            drawBits(2, gapLfsr, gap);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            // a paired data line rises together with the fetch after it
            paired = pairList[i] && (i + 1 < opList.size()) && (opList[i] != "F") &&
                     (opList[i + 1] == "F");
            if (opList[i] == "F") begin
                driveFetch(i);
                waitDone(1'b0, 1'b1);
            end else if (paired) begin
                driveData(i);
                driveFetch(i + 1);
                waitDone(1'b1, 1'b1);
                i++;
            end else begin
                driveData(i);
                waitDone(1'b1, 1'b0);
            end
            i++;
        end
    endtask

    // stalls of 1 to 3 cycles, one level at a time, then at least one active cycle
    initial begin : stallGen
        int left;
        int pick;
        int kind;
        int len;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        left = 0;
        forever begin
            @(posedge clk);
            if (rst || !stallOn) begin
                rdy <= 1'b1;
                ioBufferFull <= 1'b0;
                left = 0;
            end else if (left > 0) begin
                left--;
            end else if (!rdy || ioBufferFull) begin
                rdy <= 1'b1;
                ioBufferFull <= 1'b0;
            end else begin
                drawBits(3, stallLfsr, pick);
                if (pick < 2) begin
                    drawBits(1, stallLfsr, kind);
                    drawBits(2, stallLfsr, len);
                    len = (len % 3) + 1;
                    if (kind == 0) begin
                        rdy <= 1'b0;
                    end else begin
                        ioBufferFull <= 1'b1;
                    end
                    left = len - 1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (traceLoaded);
        repeat (limitCycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limitCycles);
        $display("Errors found");
        $finish;
    end

    initial begin : mainFlow
        logic ok;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        fetchExp  = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = '0;
        dataAddr  = '0;
        dataWdata = '0;
        dataExp   = '0;
        runDone   = 1'b0;
        stallOn   = 1'b0;
        loadTrace(ok);
        if (!ok) begin
            $display("could not read any operation from mem_trace.txt");
            $display("Errors found");
            $finish;
        end else begin
            // two passes over the trace
            limitCycles = opList.size() * 2 * 20 + 200;
            traceLoaded = 1'b1;
            while (rst) begin
                @(posedge clk);
            end
            repeat (3) @(posedge clk);
            runPass();
            stallOn <= 1'b1;
            runPass();
            repeat (4) @(posedge clk);
            runDone <= 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            if (errorCount == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// ==== mem_trace.txt ====
# op addr(hex) len value(hex) pair; S value is store data, L and F value is expected result
# pair 1 on an L or S line issues it in the same cycle as the F line after it
S 00100 4 12345678 0
L 00100 4 12345678 0
L 00100 2 00005678 0
L 00102 2 00001234 0
L 00101 1 00000056 0
L 00103 1 00000012 0
S 00104 2 0000beef 0
S 00106 1 000000aa 0
S 00107 1 00000055 0
L 00104 4 55aabeef 0
F 00104 4 55aabeef 0
F 00100 4 12345678 0
L 00105 2 0000aabe 0
S 00200 4 00000013 0
S 00204 4 00a00093 0
F 00200 4 00000013 0
F 00204 4 00a00093 0
F 00202 4 00930000 0
L 00203 2 00009300 0
S 00fff 1 0000007e 0
L 00fff 1 0000007e 0
S 00ffc 2 0000c0de 0
S 00ffe 1 00000011 0
F 00ffc 4 7e11c0de 0
L 10100 4 12345678 0
S 00300 4 cafef00d 1
F 00100 4 12345678 0
L 00300 4 cafef00d 1
F 00200 4 00000013 0
L 00302 2 0000cafe 0
S 00301 2 00001122 0
L 00300 4 ca11220d 0
L 00300 1 0000000d 0
F 00300 4 ca11220d 0

// ==== sim.f ====
memPkg.sv
byteRam.sv
memCtrl.sv
memSystem.sv
tbClock.sv
tbChecker.sv
memSystem_assert.sv
tbMemSystem.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = tbMemSystem
FILELIST   = sim.f
LINT_FLAGS = --lint-only --timing --timescale 1ns/10ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/10ps
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
